/* project.f */
rtl/nodeStatePkg.sv
rtl/memPortIf.sv
rtl/nodeMemory.sv
rtl/clusterScanner.sv
rtl/routingNodeTop.sv
verif/scanChecker.sv
verif/routingNodeTb.sv

/* rtl/clusterScanner.sv */
`timescale 1ns/10ps

// one pass over the neighbor table
// collects same-cluster neighbors that beat our own qValue and tracks
// the best neighbor over all clusters
module clusterScanner (
	input logic clock,
	input logic arstN,

	// host access, only honoured outside a scan
	input nodeStatePkg::memAddrT hostAddress,
	input logic hostWriteEnable,
	input nodeStatePkg::stateWordT hostWriteData,
	output nodeStatePkg::stateWordT hostReadData,

	// scan control
	input logic start,
	input nodeStatePkg::nodeIdT myClusterId,
	input nodeStatePkg::qValueT myQValue,
	output logic busy,
	output logic done,

	// scan results
	output nodeStatePkg::stateWordT betterCount,
	output nodeStatePkg::nodeIdT bestNeighborId,
	output nodeStatePkg::qValueT bestQValue,

	memPortIf.requester mem
);

	nodeStatePkg::scanStateT state;

	// walk position and table length
	nodeStatePkg::entryIndexT entryIndex;
	nodeStatePkg::entryIndexT entryCount;
	logic lastEntry;

	// next free betterneighbors slot, also the final count
	nodeStatePkg::betterIndexT betterIndex;

	// values captured at start
	nodeStatePkg::nodeIdT scanClusterId;
	nodeStatePkg::qValueT scanQValue;

	// entry being looked at
	nodeStatePkg::nodeIdT currentId;
	nodeStatePkg::nodeIdT currentCluster;
	nodeStatePkg::qValueT currentQ;

	logic newBest;
	logic qualifies;

	// byte address of word number index in a table
	function automatic nodeStatePkg::memAddrT entryAddr(
		input nodeStatePkg::memAddrT base,
		input nodeStatePkg::entryIndexT index
	);
		nodeStatePkg::memAddrT offset;
		offset = nodeStatePkg::memAddrT'({index, 1'b0});
		return base + offset;
	endfunction

	assign busy = (state != nodeStatePkg::idle) && (state != nodeStatePkg::finish);
	assign done = (state == nodeStatePkg::finish);

	// qValue word is on the bus during readQ
	assign currentQ = mem.readData;

	assign lastEntry = (nodeStatePkg::entryIndexT'(entryIndex + 1'b1) == entryCount);

	// first entry always taken, later ones only when strictly higher
	assign newBest = (entryIndex == '0) || (currentQ > bestQValue);

	// own cluster, better than us, and room left in the list
	assign qualifies = (currentCluster == scanClusterId) &&
		(currentQ > scanQValue) &&
		(betterIndex < nodeStatePkg::betterIndexT'(nodeStatePkg::maxBetter));

	// host sees whatever word is on the bus
	// during a scan that is the scanner's current access
	assign hostReadData = mem.readData;

	// memory port mux
	always_comb begin
		mem.address = hostAddress;
		mem.writeEnable = 1'b0;
		mem.writeData = hostWriteData;
		case (state)
			// busy is low here, host owns the port
			nodeStatePkg::idle,
			nodeStatePkg::finish: begin
				mem.writeEnable = hostWriteEnable;
			end
			nodeStatePkg::readCount: begin
				mem.address = nodeStatePkg::neighborCountAddr;
			end
			nodeStatePkg::readId: begin
				mem.address = entryAddr(nodeStatePkg::neighborIdBase, entryIndex);
			end
			nodeStatePkg::readCluster: begin
				mem.address = entryAddr(nodeStatePkg::clusterIdBase, entryIndex);
			end
			nodeStatePkg::readQ: begin
				mem.address = entryAddr(nodeStatePkg::qValueBase, entryIndex);
			end
			nodeStatePkg::writeBetter: begin
				mem.address = entryAddr(nodeStatePkg::betterNeighborBase,
					nodeStatePkg::entryIndexT'(betterIndex));
				mem.writeEnable = 1'b1;
				mem.writeData = currentId;
			end
			nodeStatePkg::writeCount: begin
				mem.address = nodeStatePkg::betterCountAddr;
				mem.writeEnable = 1'b1;
				mem.writeData = nodeStatePkg::stateWordT'(betterIndex);
			end
			default: begin
				mem.writeEnable = 1'b0;
			end
		endcase
	end

	// control state and results
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= nodeStatePkg::idle;
			entryIndex <= '0;
			entryCount <= '0;
			betterIndex <= '0;
			betterCount <= '0;
			bestNeighborId <= '0;
			bestQValue <= '0;
		end else begin
			case (state)
				nodeStatePkg::idle: begin
					if (start) begin
						// results restart from zero
						entryIndex <= '0;
						betterIndex <= '0;
						betterCount <= '0;
						bestNeighborId <= '0;
						bestQValue <= '0;
						state <= nodeStatePkg::readCount;
					end
				end
				nodeStatePkg::readCount: begin
					// clamp to table size
					if (mem.readData > nodeStatePkg::stateWordT'(nodeStatePkg::maxNeighbors)) begin
						entryCount <= nodeStatePkg::entryIndexT'(nodeStatePkg::maxNeighbors);
					end else begin
						entryCount <= nodeStatePkg::entryIndexT'(mem.readData);
					end
					if (mem.readData == '0) begin
						state <= nodeStatePkg::writeCount;
					end else begin
						state <= nodeStatePkg::readId;
					end
				end
				nodeStatePkg::readId: begin
					state <= nodeStatePkg::readCluster;
				end
				nodeStatePkg::readCluster: begin
					state <= nodeStatePkg::readQ;
				end
				nodeStatePkg::readQ: begin
					if (newBest) begin
						bestNeighborId <= currentId;
						bestQValue <= currentQ;
					end
					if (qualifies) begin
						state <= nodeStatePkg::writeBetter;
					end else if (lastEntry) begin
						state <= nodeStatePkg::writeCount;
					end else begin
						entryIndex <= entryIndex + 1'b1;
						state <= nodeStatePkg::readId;
					end
				end
				nodeStatePkg::writeBetter: begin
					betterIndex <= betterIndex + 1'b1;
					if (lastEntry) begin
						state <= nodeStatePkg::writeCount;
					end else begin
						entryIndex <= entryIndex + 1'b1;
						state <= nodeStatePkg::readId;
					end
				end
				nodeStatePkg::writeCount: begin
					betterCount <= nodeStatePkg::stateWordT'(betterIndex);
					state <= nodeStatePkg::finish;
				end
				nodeStatePkg::finish: begin
					// done shows for this one cycle
					state <= nodeStatePkg::idle;
				end
				default: begin
					state <= nodeStatePkg::idle;
				end
			endcase
		end
	end

	// captured words, no reset needed
	always_ff @(posedge clock) begin
		if (state == nodeStatePkg::idle && start) begin
			scanClusterId <= myClusterId;
			scanQValue <= myQValue;
		end
		if (state == nodeStatePkg::readId) begin
			currentId <= mem.readData;
		end
		if (state == nodeStatePkg::readCluster) begin
			currentCluster <= mem.readData;
		end
	end

endmodule

/* rtl/memPortIf.sv */
`timescale 1ns/10ps

// single word-wide port, combinational read and clocked write
interface memPortIf;

	nodeStatePkg::memAddrT address;
	logic writeEnable;
	nodeStatePkg::stateWordT writeData;
	nodeStatePkg::stateWordT readData;

	// side that issues accesses
	modport requester (
		output address,
		output writeEnable,
		output writeData,
		input readData
	);

	// side that holds the storage
	modport memory (
		input address,
		input writeEnable,
		input writeData,
		output readData
	);

endinterface

/* rtl/nodeMemory.sv */
`timescale 1ns/10ps

// node state memory
// byte cells, words stored high byte first
//
// map used by the scanner (byte addresses)
//   0x048  neighborID, 64 words
//   0x0C8  clusterID, 64 words
//   0x1C8  qValue, 64 words
//   0x668  betterneighbors, 16 words
//   0x68A  neighborCount
//   0x68C  betterneighborCount
// flags, knownSinks, worstHops, batteryStat, sinkIDs, HCM and the
// other counts share the same array, only the host touches them
module nodeMemory (
	input logic clock,
	memPortIf.memory mem
);

	logic [nodeStatePkg::byteWidth-1:0] cells [nodeStatePkg::memDepth];

	// second byte of the word, wraps at the top of the array
	nodeStatePkg::memAddrT lowAddress;

	assign lowAddress = mem.address + 1'b1;

	// read is combinational
	// high byte at the even address, low byte right after it
	always_comb begin
		mem.readData = {cells[mem.address], cells[lowAddress]};
	end

	// write both bytes at the edge
	always_ff @(posedge clock) begin
		if (mem.writeEnable) begin
			cells[mem.address] <= mem.writeData[nodeStatePkg::wordWidth-1:nodeStatePkg::byteWidth];
			cells[lowAddress] <= mem.writeData[nodeStatePkg::byteWidth-1:0];
		end
	end

endmodule

/* rtl/nodeStatePkg.sv */
package nodeStatePkg;

	// memory geometry
	localparam int memDepth = 2048;
	localparam int byteWidth = 8;
	localparam int wordWidth = 16;

	// table sizes
	localparam int maxNeighbors = 64;
	localparam int maxBetter = 8;

	// byte address into the node memory
	typedef logic [$clog2(memDepth)-1:0] memAddrT;

	// one big-endian state word
	typedef logic [wordWidth-1:0] stateWordT;

	// node and cluster identifiers share one width
	typedef logic [wordWidth-1:0] nodeIdT;

	// unsigned fixed point, same layout as the stored qValue words
	typedef logic [wordWidth-1:0] qValueT;

	// index wide enough to hold the full count, not only the last slot
	typedef logic [$clog2(maxNeighbors+1)-1:0] entryIndexT;
	typedef logic [$clog2(maxBetter+1)-1:0] betterIndexT;

	// word tables, two bytes per entry
	localparam memAddrT neighborIdBase = 11'h048;
	localparam memAddrT clusterIdBase = 11'h0C8;
	localparam memAddrT qValueBase = 11'h1C8;
	localparam memAddrT betterNeighborBase = 11'h668;

	// single count words
	localparam memAddrT neighborCountAddr = 11'h68A;
	localparam memAddrT betterCountAddr = 11'h68C;

	// scanner sequence, one memory access per state except idle and finish
	typedef enum logic [2:0] {
		idle,
		readCount,
		readId,
		readCluster,
		readQ,
		writeBetter,
		writeCount,
		finish
	} scanStateT;

endpackage

/* rtl/routingNodeTop.sv */
`timescale 1ns/10ps

// neighbor-table engine, scanner in front of the node memory
module routingNodeTop (
	input logic clock,
	input logic arstN,

	// host port
	input nodeStatePkg::memAddrT hostAddress,
	input logic hostWriteEnable,
	input nodeStatePkg::stateWordT hostWriteData,
	output nodeStatePkg::stateWordT hostReadData,

	// scan control
	input logic start,
	input nodeStatePkg::nodeIdT myClusterId,
	input nodeStatePkg::qValueT myQValue,
	output logic busy,
	output logic done,

	// scan results
	output nodeStatePkg::stateWordT betterCount,
	output nodeStatePkg::nodeIdT bestNeighborId,
	output nodeStatePkg::qValueT bestQValue
);

	// scanner is the only requester
	memPortIf memBus ();

	clusterScanner u_scanner (
		.clock (clock),
		.arstN (arstN),
		.hostAddress (hostAddress),
		.hostWriteEnable (hostWriteEnable),
		.hostWriteData (hostWriteData),
		.hostReadData (hostReadData),
		.start (start),
		.myClusterId (myClusterId),
		.myQValue (myQValue),
		.busy (busy),
		.done (done),
		.betterCount (betterCount),
		.bestNeighborId (bestNeighborId),
		.bestQValue (bestQValue),
		.mem (memBus.requester)
	);

	// storage has no reset
	nodeMemory u_memory (
		.clock (clock),
		.mem (memBus.memory)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -f project.f --top-module routingNodeTb -o routingNodeSim \
	&& ./obj_dir/routingNodeSim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "run result: pass" && exit 0 \
	|| echo "run result: fail"
exit 1

/* verif/routingNodeTb.sv */
`timescale 1ns/10ps

// drives the neighbor-table engine from the stimulus file
module routingNodeTb;

	// cycle budget per file record
	// well above the longest scan
	localparam int cyclesPerRecord = 300;

	logic clock;
	logic arstN;
	nodeStatePkg::memAddrT hostAddress;
	logic hostWriteEnable;
	nodeStatePkg::stateWordT hostWriteData;
	nodeStatePkg::stateWordT hostReadData;
	logic start;
	nodeStatePkg::nodeIdT myClusterId;
	nodeStatePkg::qValueT myQValue;
	logic busy;
	logic done;
	nodeStatePkg::stateWordT betterCount;
	nodeStatePkg::nodeIdT bestNeighborId;
	nodeStatePkg::qValueT bestQValue;

	// expectation strobe to the checker
	logic expectStrobe;
	logic expectRead;
	nodeStatePkg::memAddrT expectAddress;
	nodeStatePkg::stateWordT expectData;
	nodeStatePkg::stateWordT expectCount;
	nodeStatePkg::nodeIdT expectId;
	nodeStatePkg::qValueT expectQ;

	int mismatchCount;
	int failureCount;
	int driverFailures = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	int recordCount = 0;
	int fileHandle;
	int scanCode;
	logic [7:0] recordKind;
	logic [31:0] fieldA;
	logic [31:0] fieldB;
	logic [31:0] fieldC;
	logic [8*128-1:0] skippedLine;

	routingNodeTop u_dut (
		.clock (clock),
		.arstN (arstN),
		.hostAddress (hostAddress),
		.hostWriteEnable (hostWriteEnable),
		.hostWriteData (hostWriteData),
		.hostReadData (hostReadData),
		.start (start),
		.myClusterId (myClusterId),
		.myQValue (myQValue),
		.busy (busy),
		.done (done),
		.betterCount (betterCount),
		.bestNeighborId (bestNeighborId),
		.bestQValue (bestQValue)
	);

	scanChecker u_checker (
		.clock (clock),
		.arstN (arstN),
		.busy (busy),
		.done (done),
		.betterCount (betterCount),
		.bestNeighborId (bestNeighborId),
		.bestQValue (bestQValue),
		.hostReadData (hostReadData),
		.expectStrobe (expectStrobe),
		.expectRead (expectRead),
		.expectAddress (expectAddress),
		.expectData (expectData),
		.expectCount (expectCount),
		.expectId (expectId),
		.expectQ (expectQ),
		.mismatchCount (mismatchCount),
		.failureCount (failureCount)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// run limit sized from the record count
	always @(posedge clock) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: simulation timed out waiting for done after %0d cycles",
				cycleCount);
			$display("Errors: %0d mismatches, %0d checker failures, %0d driver failures",
				mismatchCount, failureCount, driverFailures);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// enable held for one edge only
	task automatic hostWrite(input logic [31:0] address, input logic [31:0] data);
		@(posedge clock);
		hostAddress <= nodeStatePkg::memAddrT'(address);
		hostWriteData <= nodeStatePkg::stateWordT'(data);
		hostWriteEnable <= 1'b1;
		@(posedge clock);
		hostWriteEnable <= 1'b0;
	endtask

	// address out and expectation handed over in the same cycle
	task automatic readBack(input logic [31:0] address, input logic [31:0] data);
		@(posedge clock);
		hostAddress <= nodeStatePkg::memAddrT'(address);
		expectAddress <= nodeStatePkg::memAddrT'(address);
		expectData <= nodeStatePkg::stateWordT'(data);
		expectRead <= 1'b1;
		expectStrobe <= 1'b1;
		@(posedge clock);
		expectStrobe <= 1'b0;
	endtask

	task automatic runScan(input logic [31:0] clusterId, input logic [31:0] qValue);
		@(posedge clock);
		myClusterId <= nodeStatePkg::nodeIdT'(clusterId);
		myQValue <= nodeStatePkg::qValueT'(qValue);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		// stray start with other values lands inside the scan
		@(posedge clock);
		myClusterId <= ~nodeStatePkg::nodeIdT'(clusterId);
		myQValue <= '0;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		// wait for the done pulse
		@(negedge clock);
		while (done !== 1'b1) begin
			@(negedge clock);
		end
	endtask

	task automatic scanResults(
		input logic [31:0] count,
		input logic [31:0] bestId,
		input logic [31:0] bestQ
	);
		@(posedge clock);
		expectCount <= nodeStatePkg::stateWordT'(count);
		expectId <= nodeStatePkg::nodeIdT'(bestId);
		expectQ <= nodeStatePkg::qValueT'(bestQ);
		expectRead <= 1'b0;
		expectStrobe <= 1'b1;
		@(posedge clock);
		expectStrobe <= 1'b0;
	endtask

	task automatic flagShortRecord(input logic [7:0] kind);
		$display("record %s in the stimulus file is missing fields", kind);
		driverFailures++;
	endtask

	initial begin
		arstN = 1'b0;
		hostAddress = '0;
		hostWriteEnable = 1'b0;
		hostWriteData = '0;
		start = 1'b0;
		myClusterId = '0;
		myQValue = '0;
		expectStrobe = 1'b0;
		expectRead = 1'b0;
		expectAddress = '0;
		expectData = '0;
		expectCount = '0;
		expectId = '0;
		expectQ = '0;
		// first pass only counts records
		fileHandle = $fopen("verif/testdata_scan.txt", "r");
		if (fileHandle == 0) begin
			$display("could not open verif/testdata_scan.txt");
			driverFailures++;
		end else begin
			while ($fscanf(fileHandle, "%s", recordKind) == 1) begin
				if (recordKind != "#") recordCount++;
				scanCode = $fgets(skippedLine, fileHandle);
			end
			$fclose(fileHandle);
		end
		cycleLimit = recordCount * cyclesPerRecord + 20;
		repeat (3) @(posedge clock);
		arstN <= 1'b1;
		if (driverFailures == 0) begin
			fileHandle = $fopen("verif/testdata_scan.txt", "r");
			while ($fscanf(fileHandle, "%s", recordKind) == 1) begin
				case (recordKind)
					"#": scanCode = $fgets(skippedLine, fileHandle);
					"W": begin
						scanCode = $fscanf(fileHandle, "%h %h", fieldA, fieldB);
						if (scanCode == 2) begin
							hostWrite(fieldA, fieldB);
						end else begin
							flagShortRecord(recordKind);
						end
					end
					"R": begin
						scanCode = $fscanf(fileHandle, "%h %h", fieldA, fieldB);
						if (scanCode == 2) begin
							readBack(fieldA, fieldB);
						end else begin
							flagShortRecord(recordKind);
						end
					end
					"S": begin
						scanCode = $fscanf(fileHandle, "%h %h", fieldA, fieldB);
						if (scanCode == 2) begin
							runScan(fieldA, fieldB);
						end else begin
							flagShortRecord(recordKind);
						end
					end
					"E": begin
						scanCode = $fscanf(fileHandle, "%h %h %h", fieldA, fieldB, fieldC);
						if (scanCode == 3) begin
							scanResults(fieldA, fieldB, fieldC);
						end else begin
							flagShortRecord(recordKind);
						end
					end
					default: begin
						$display("unknown record kind %s in the stimulus file", recordKind);
						driverFailures++;
						scanCode = $fgets(skippedLine, fileHandle);
					end
				endcase
			end
			$fclose(fileHandle);
		end
		repeat (2) @(posedge clock);
		$display("Errors: %0d mismatches, %0d checker failures, %0d driver failures",
			mismatchCount, failureCount, driverFailures);
		if (mismatchCount == 0 && failureCount == 0 && driverFailures == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* verif/scanChecker.sv */
`timescale 1ns/10ps

// watches the engine ports and compares them with driver expectations
// results are latched at done, host reads are compared in the strobe cycle
module scanChecker (
	input logic clock,
	input logic arstN,

	// DUT outputs
	input logic busy,
	input logic done,
	input nodeStatePkg::stateWordT betterCount,
	input nodeStatePkg::nodeIdT bestNeighborId,
	input nodeStatePkg::qValueT bestQValue,
	input nodeStatePkg::stateWordT hostReadData,

	// expectation strobe from the driver
	input logic expectStrobe,
	input logic expectRead,
	input nodeStatePkg::memAddrT expectAddress,
	input nodeStatePkg::stateWordT expectData,
	input nodeStatePkg::stateWordT expectCount,
	input nodeStatePkg::nodeIdT expectId,
	input nodeStatePkg::qValueT expectQ,

	output int mismatchCount,
	output int failureCount
);

	int mismatches = 0;
	int failures = 0;

	// set while reset is held, cleared on the first sample after it
	logic inReset = 1'b0;

	// results seen at the last done
	logic doneSeen = 1'b0;
	nodeStatePkg::stateWordT doneCount;
	nodeStatePkg::nodeIdT doneId;
	nodeStatePkg::qValueT doneQ;

	assign mismatchCount = mismatches;
	assign failureCount = failures;

	task automatic reportMismatch(
		input string signalName,
		input logic [15:0] expected,
		input logic [15:0] actual
	);
		$display("Mismatch at %0t: %s expected %h actual %h",
			$time, signalName, expected, actual);
		mismatches++;
	endtask

	// falling edge, all driver and DUT updates have settled
	always @(negedge clock) begin
		if (!arstN) begin
			inReset = 1'b1;
			doneSeen = 1'b0;
		end else begin
			// idle state right after reset release
			if (inReset) begin
				inReset = 1'b0;
				if (busy !== 1'b0 || done !== 1'b0) begin
					$display("busy or done is not low after reset at %0t", $time);
					failures++;
				end
				if (betterCount !== '0) reportMismatch("betterCount", '0, betterCount);
				if (bestNeighborId !== '0) reportMismatch("bestNeighborId", '0, bestNeighborId);
				if (bestQValue !== '0) reportMismatch("bestQValue", '0, bestQValue);
			end
			// busy has to drop together with done
			if (done === 1'b1) begin
				if (busy !== 1'b0) begin
					$display("busy still high while done is high at %0t", $time);
					failures++;
				end
				doneSeen = 1'b1;
				doneCount = betterCount;
				doneId = bestNeighborId;
				doneQ = bestQValue;
			end
			if (expectStrobe === 1'b1) begin
				if (expectRead) begin
					if (hostReadData !== expectData) begin
						reportMismatch($sformatf("hostReadData[%h]", expectAddress),
							expectData, hostReadData);
					end
				end else if (!doneSeen) begin
					$display("scan results expected at %0t but no scan finished", $time);
					failures++;
				end else begin
					if (doneCount !== expectCount) reportMismatch("betterCount", expectCount, doneCount);
					if (doneId !== expectId) reportMismatch("bestNeighborId", expectId, doneId);
					if (doneQ !== expectQ) reportMismatch("bestQValue", expectQ, doneQ);
					doneSeen = 1'b0;
				end
			end
		end
	end

endmodule

/* verif/testdata_scan.txt */
# W addr data | R addr data | S myCluster myQ | E betterCount bestId bestQ
# all fields hex, addresses are byte addresses
# host write and read-back, odd address shows byte order
W 000 1234
W 002 abcd
R 000 1234
R 001 34ab
R 002 abcd
# reference table, four neighbors
W 68a 0004
W 048 0001
W 04a 0003
W 04c 0004
W 04e 0006
W 0c8 0009
W 0ca 0001
W 0cc 0001
W 0ce 0003
W 1c8 0780
W 1ca 0500
W 1cc 0460
W 1ce 0140
S 0001 0480
E 0001 0001 0780
R 668 0003
R 68c 0001
# tie on the maximum, first one wins
W 1c8 0100
W 1ca 0600
W 1ce 0600
S 0001 0480
E 0001 0003 0600
# ten qualifying neighbors, list stops at eight
W 678 beef
W 68a 000a
W 050 0020
W 052 0021
W 054 0022
W 056 0023
W 058 0024
W 05a 0025
W 0c8 0005
W 0ca 0005
W 0cc 0005
W 0ce 0005
W 0d0 0005
W 0d2 0005
W 0d4 0005
W 0d6 0005
W 0d8 0005
W 0da 0005
W 1d0 0200
W 1d2 0201
W 1d4 0202
W 1d6 0203
W 1d8 0204
W 1da 0700
S 0005 0050
E 0008 0025 0700
R 68c 0008
R 668 0001
R 676 0023
R 678 beef
# empty table
W 68a 0000
S 0005 0050
E 0000 0000 0000
R 68c 0000
